// File: all.f
verilog/bp_pkg.sv
verilog/counter_table.sv
verilog/branch_rank.sv
verilog/history_register.sv
verilog/branch_predictor.sv
verilog/branch_stack.sv
verilog/fetch_branch_unit.sv
bench/tb_fetch_branch_unit.sv

// File: bench/tb_fetch_branch_unit.sv
`timescale 1ns/10ps

module tb_fetch_branch_unit;
    import bp_pkg::*;

    localparam int TEST_COUNT = 5;
    // The longest test runs about 30 cycles
    localparam int MAX_CYCLES = TEST_COUNT * 60;

    logic                         clock;
    logic                         reset;
    addr_t    [FETCH_WIDTH-1:0]   pcs;
    logic     [FETCH_WIDTH-1:0]   branch_mask;
    logic     [FETCH_WIDTH-1:0]   btb_hits;
    logic                         fetch_valid;
    logic                         resolve_valid;
    tag_t                         resolve_tag;
    logic                         taken;
    logic                         mispred;
    logic     [FETCH_WIDTH-1:0]   branches_taken;
    tag_t     [FETCH_WIDTH-1:0]   branch_tags;
    logic                         stack_full;

    int          errors;
    int          checks;
    int          error_base;
    int          check_base;
    int          cycle_count;
    logic [31:0] lfsr;

    // Reference model of tables, history and stack
    logic [1:0] m_gshare [PHT_SIZE];
    logic [1:0] m_simple [PHT_SIZE];
    logic [1:0] m_chooser [PHT_SIZE];
    history_t   m_history;
    tag_t       m_head;
    int         m_free;
    pht_index_t p_gidx [STACK_DEPTH];
    pht_index_t p_sidx [STACK_DEPTH];
    history_t   p_hist [STACK_DEPTH];
    logic       p_gtaken [STACK_DEPTH];
    logic       p_staken [STACK_DEPTH];
    tag_t       pending [$];

    fetch_branch_unit i_dut (
        .clock          (clock),
        .reset          (reset),
        .pcs            (pcs),
        .branch_mask    (branch_mask),
        .btb_hits       (btb_hits),
        .fetch_valid    (fetch_valid),
        .resolve_valid  (resolve_valid),
        .resolve_tag    (resolve_tag),
        .taken          (taken),
        .mispred        (mispred),
        .branches_taken (branches_taken),
        .branch_tags    (branch_tags),
        .stack_full     (stack_full)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic random_pc(input logic [5:0] low, output addr_t pc);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < 26; k++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        pc = {bits[25:0], low};
    endtask

    task automatic random_low(output logic [5:0] low);
        low = '0;
        for (int k = 0; k < 6; k++) begin
            lfsr = lfsr_step(lfsr);
            low  = {low[4:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got == expected) else begin
            $display("error %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - check_base, errors - error_base);
        check_base = checks;
        error_base = errors;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset         <= 1'b1;
        fetch_valid   <= 1'b0;
        resolve_valid <= 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        for (int k = 0; k < PHT_SIZE; k++) begin
            m_gshare[k]  = '0;
            m_simple[k]  = '0;
            m_chooser[k] = '0;
        end
        m_history = '0;
        m_head    = '0;
        m_free    = STACK_DEPTH;
        pending.delete();
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        fetch_valid   <= 1'b0;
        resolve_valid <= 1'b0;
        @(negedge clock);
        check_value("stack_full", stack_full, m_free < FETCH_WIDTH);
    endtask

    task automatic fetch_group(input addr_t pc0, input addr_t pc1, input logic [1:0] mask,
                               input logic [1:0] btb, output logic [1:0] got_taken,
                               output tag_t [FETCH_WIDTH-1:0] got_tags);
        addr_t [FETCH_WIDTH-1:0] lane_pc;
        history_t                lane_hist;
        history_t                last_hist;
        pht_index_t              gidx;
        pht_index_t              sidx;
        logic                    pred;
        logic                    last_pred;
        tag_t                    tag;
        int                      rank;
        @(posedge clock);
        pcs           <= {pc1, pc0};
        branch_mask   <= mask;
        btb_hits      <= btb;
        fetch_valid   <= 1'b1;
        resolve_valid <= 1'b0;
        @(negedge clock);
        lane_pc = {pc1, pc0};
        check_value("stack_full", stack_full, m_free < FETCH_WIDTH);
        rank = 0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (mask[i]) begin
                lane_hist = history_t'(m_history << rank);
                sidx      = lane_pc[i][HISTORY_BITS-1:0];
                gidx      = sidx ^ lane_hist;
                // Chooser counts only with a BTB hit
                pred = (btb[i] && m_chooser[sidx][1]) ? m_gshare[gidx][1] : m_simple[sidx][1];
                tag  = tag_t'(m_head + rank);
                check_value($sformatf("branches_taken[%0d]", i), branches_taken[i], pred);
                check_value($sformatf("branch_tags[%0d]", i), branch_tags[i], tag);
                p_gidx[tag]   = gidx;
                p_sidx[tag]   = sidx;
                p_hist[tag]   = lane_hist;
                p_gtaken[tag] = m_gshare[gidx][1];
                p_staken[tag] = m_simple[sidx][1];
                pending.push_back(tag);
                last_hist = lane_hist;
                last_pred = pred;
                rank++;
            end
        end
        got_taken = branches_taken;
        got_tags  = branch_tags;
        if (rank > 0) begin
            m_history = {last_hist[HISTORY_BITS-2:0], last_pred};
            m_head    = tag_t'(m_head + rank);
            m_free    = m_free - rank;
        end
    endtask

    task automatic resolve(input tag_t tag, input logic tk, input logic mis);
        logic gright;
        logic sright;
        @(posedge clock);
        fetch_valid   <= 1'b0;
        resolve_valid <= 1'b1;
        resolve_tag   <= tag;
        taken         <= tk;
        mispred       <= mis;
        @(negedge clock);
        check_value("stack_full", stack_full, m_free < FETCH_WIDTH);
        gright = (p_gtaken[tag] == tk);
        sright = (p_staken[tag] == tk);
        m_gshare[p_gidx[tag]] = saturate(m_gshare[p_gidx[tag]], tk);
        m_simple[p_sidx[tag]] = saturate(m_simple[p_sidx[tag]], tk);
        if (gright != sright) begin
            m_chooser[p_sidx[tag]] = saturate(m_chooser[p_sidx[tag]], gright);
        end
        if (mis) begin
            m_history = {p_hist[tag][HISTORY_BITS-2:0], tk};
            m_head    = tag_t'(tag + 1);
            m_free    = STACK_DEPTH;
            pending.delete();
        end else begin
            m_free++;
            for (int k = 0; k < pending.size(); k++) begin
                if (pending[k] == tag) begin
                    pending.delete(k);
                    break;
                end
            end
        end
    endtask

    task automatic resolve_all(input logic tk);
        while (pending.size() > 0) begin
            resolve(pending[0], tk, 1'b0);
        end
    endtask

    // Leaves the chooser at 2 and the simple counter at 1 for this PC
    task automatic train_chooser(input addr_t pc);
        logic [1:0]              t;
        tag_t [FETCH_WIDTH-1:0]  g;
        logic [4:0]              outcomes;
        outcomes = 5'b00111;
        for (int k = 0; k < 5; k++) begin
            fetch_group(pc, pc, 2'b01, 2'b00, t, g);
            resolve(g[0], outcomes[k], 1'b0);
        end
    endtask

    task automatic test_reset_state();
        addr_t                  pc0;
        addr_t                  pc1;
        logic [5:0]             low0;
        logic [5:0]             low1;
        logic [1:0]             t;
        tag_t [FETCH_WIDTH-1:0] g;
        apply_reset();
        for (int k = 0; k < 3; k++) begin
            random_low(low0);
            random_pc(low0, pc0);
            random_low(low1);
            random_pc(low1, pc1);
            fetch_group(pc0, pc1, 2'b11, 2'b11, t, g);
            check_value("branches_taken", t, 2'b00);
            if (k == 0) begin
                check_value("branch_tags[0]", g[0], 0);
                check_value("branch_tags[1]", g[1], 1);
            end
        end
        resolve_all(1'b0);
        idle_cycle();
        finish_test("reset_state");
    endtask

    task automatic test_simple_training();
        addr_t                  pc;
        logic [1:0]             t;
        tag_t [FETCH_WIDTH-1:0] g;
        logic [4:0]             outcomes;
        logic [4:0]             expected;
        apply_reset();
        random_pc(6'h2a, pc);
        outcomes = 5'b00011;
        expected = 5'b00100;
        for (int k = 0; k < 5; k++) begin
            fetch_group(pc, pc, 2'b01, 2'b00, t, g);
            if (k == 2 || k == 4) begin
                check_value("branches_taken[0]", t[0], expected[k]);
            end
            resolve(g[0], outcomes[k], 1'b0);
        end
        idle_cycle();
        finish_test("simple_training");
    endtask

    task automatic test_tag_allocation();
        addr_t                  pc0;
        addr_t                  pc1;
        logic [1:0]             t;
        tag_t [FETCH_WIDTH-1:0] g;
        apply_reset();
        random_pc(6'h11, pc0);
        random_pc(6'h22, pc1);
        fetch_group(pc0, pc1, 2'b10, 2'b00, t, g);
        check_value("branch_tags[1]", g[1], 0);
        fetch_group(pc0, pc1, 2'b11, 2'b00, t, g);
        check_value("branch_tags[0]", g[0], 1);
        check_value("branch_tags[1]", g[1], 2);
        resolve_all(1'b0);
        for (int k = 0; k < 4; k++) begin
            fetch_group(pc0, pc1, 2'b11, 2'b00, t, g);
        end
        idle_cycle();
        check_value("stack_full", stack_full, 1);
        resolve(pending[0], 1'b0, 1'b0);
        idle_cycle();
        check_value("stack_full", stack_full, 1);
        resolve(pending[0], 1'b0, 1'b0);
        idle_cycle();
        check_value("stack_full", stack_full, 0);
        resolve_all(1'b0);
        idle_cycle();
        finish_test("tag_allocation");
    endtask

    task automatic test_history_gshare();
        addr_t                  pc;
        logic [1:0]             t;
        tag_t [FETCH_WIDTH-1:0] g;
        apply_reset();
        random_pc(6'h05, pc);
        train_chooser(pc);
        // Both predictors wrong, so only the simple counter moves back to taken
        fetch_group(pc, pc, 2'b01, 2'b00, t, g);
        resolve(g[0], 1'b1, 1'b0);
        fetch_group(pc, pc, 2'b01, 2'b01, t, g);
        check_value("branches_taken[0]", t[0], 0);
        fetch_group(pc, pc, 2'b01, 2'b00, t, g);
        check_value("branches_taken[0]", t[0], 1);
        resolve_all(1'b0);
        idle_cycle();
        finish_test("history_gshare");
    endtask

    task automatic test_mispredict_recovery();
        addr_t                  pc;
        addr_t                  pc_a;
        addr_t                  pc_b;
        logic [1:0]             t;
        tag_t [FETCH_WIDTH-1:0] g;
        tag_t                   old_tag;
        apply_reset();
        random_pc(6'h05, pc);
        train_chooser(pc);
        // Gshare slot 60 is the one the rebuilt history selects for this PC
        random_pc(6'd59, pc_a);
        fetch_group(pc_a, pc_a, 2'b01, 2'b00, t, g);
        resolve(g[0], 1'b1, 1'b0);
        random_pc(6'd50, pc_a);
        fetch_group(pc_a, pc_a, 2'b01, 2'b00, t, g);
        resolve(g[0], 1'b1, 1'b0);
        random_pc(6'd20, pc_a);
        random_pc(6'd33, pc_b);
        fetch_group(pc_a, pc_b, 2'b11, 2'b00, t, g);
        old_tag = g[0];
        random_pc(6'd17, pc_a);
        fetch_group(pc_a, pc_a, 2'b01, 2'b00, t, g);
        resolve(old_tag, 1'b1, 1'b1);
        idle_cycle();
        check_value("stack_full", stack_full, 0);
        random_pc(6'd40, pc_b);
        fetch_group(pc, pc_b, 2'b11, 2'b01, t, g);
        check_value("branch_tags[0]", g[0], tag_t'(old_tag + 1));
        check_value("branch_tags[1]", g[1], tag_t'(old_tag + 2));
        check_value("branches_taken[0]", t[0], 1);
        // An emptied stack takes three more full groups before it fills
        for (int k = 0; k < 3; k++) begin
            fetch_group(pc_a, pc_b, 2'b11, 2'b00, t, g);
        end
        idle_cycle();
        check_value("stack_full", stack_full, 1);
        finish_test("mispredict_recovery");
    endtask

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        pcs           = '0;
        branch_mask   = '0;
        btb_hits      = '0;
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
        resolve_tag   = '0;
        taken         = 1'b0;
        mispred       = 1'b0;
        errors        = 0;
        checks        = 0;
        error_base    = 0;
        check_base    = 0;
        cycle_count   = 0;
        lfsr          = 32'h3a84beef;
        test_reset_state();
        test_simple_training();
        test_tag_allocation();
        test_history_gshare();
        test_mispredict_recovery();
        $display("%0d tests, %0d checks, %0d errors", TEST_COUNT, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog/bp_pkg.sv
package bp_pkg;

    // Front end geometry
    localparam int FETCH_WIDTH  = 2;
    localparam int HISTORY_BITS = 6;

    // One entry per history pattern, so the table index and history widths match
    localparam int PHT_SIZE     = 64;

    // Branch stack sizing
    localparam int STACK_DEPTH  = 8;
    localparam int TAG_BITS     = 3;

    typedef logic [31:0]             addr_t;
    typedef logic [HISTORY_BITS-1:0] history_t;
    typedef logic [HISTORY_BITS-1:0] pht_index_t;
    typedef logic [TAG_BITS-1:0]     tag_t;

    // Direction counter, upper bit set means predict taken
    typedef logic [1:0] counter_t;

    // Chooser counter, upper bit set means trust gshare over simple
    typedef logic [1:0] chooser_t;

    // State saved with each in-flight branch until execute resolves it
    typedef struct packed {
        logic       gshare_taken;
        logic       simple_taken;
        pht_index_t gshare_index;
        // Shared by the simple and chooser tables
        pht_index_t simple_index;
        history_t   history_state;
    } bp_packet_t;

endpackage

// File: verilog/branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor (
    input  logic                                         clock,
    input  logic                                         reset,
    input  bp_pkg::addr_t      [bp_pkg::FETCH_WIDTH-1:0] pcs,
    input  logic               [bp_pkg::FETCH_WIDTH-1:0] btb_hits,
    input  bp_pkg::history_t   [bp_pkg::FETCH_WIDTH-1:0] lane_history,
    output bp_pkg::bp_packet_t [bp_pkg::FETCH_WIDTH-1:0] lane_packets,
    output logic               [bp_pkg::FETCH_WIDTH-1:0] branches_taken,
    input  logic                                         resolve_valid,
    input  logic                                         taken,
    input  bp_pkg::bp_packet_t                           resolved_packet
);
    import bp_pkg::*;

    pht_index_t [FETCH_WIDTH-1:0] gshare_index;
    pht_index_t [FETCH_WIDTH-1:0] simple_index;
    counter_t   [FETCH_WIDTH-1:0] gshare_entry;
    counter_t   [FETCH_WIDTH-1:0] simple_entry;
    chooser_t   [FETCH_WIDTH-1:0] chooser_entry;
    logic                         gshare_right;
    logic                         simple_right;
    logic                         chooser_up;
    logic                         chooser_down;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            simple_index[i] = pcs[i][HISTORY_BITS-1:0];
            gshare_index[i] = pcs[i][HISTORY_BITS-1:0] ^ lane_history[i];
        end
    end

    // Both direction tables train toward the actual outcome
    counter_table #(.entry_t(counter_t)) gshare_table (
        .clock       (clock),
        .reset       (reset),
        .read_index  (gshare_index),
        .read_entry  (gshare_entry),
        .train_valid (resolve_valid),
        .train_index (resolved_packet.gshare_index),
        .step_up     (taken),
        .step_down   (!taken)
    );

    counter_table #(.entry_t(counter_t)) simple_table (
        .clock       (clock),
        .reset       (reset),
        .read_index  (simple_index),
        .read_entry  (simple_entry),
        .train_valid (resolve_valid),
        .train_index (resolved_packet.simple_index),
        .step_up     (taken),
        .step_down   (!taken)
    );

    // Chooser only moves when exactly one predictor was right
    assign gshare_right = (resolved_packet.gshare_taken == taken);
    assign simple_right = (resolved_packet.simple_taken == taken);
    assign chooser_up   = gshare_right && !simple_right;
    assign chooser_down = simple_right && !gshare_right;

    counter_table #(.entry_t(chooser_t)) chooser_table (
        .clock       (clock),
        .reset       (reset),
        .read_index  (simple_index),
        .read_entry  (chooser_entry),
        .train_valid (resolve_valid),
        .train_index (resolved_packet.simple_index),
        .step_up     (chooser_up),
        .step_down   (chooser_down)
    );

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_packets[i].gshare_taken  = gshare_entry[i][1];
            lane_packets[i].simple_taken  = simple_entry[i][1];
            lane_packets[i].gshare_index  = gshare_index[i];
            lane_packets[i].simple_index  = simple_index[i];
            lane_packets[i].history_state = lane_history[i];
            // Without a BTB hit the chooser is not trusted
            if (btb_hits[i] && chooser_entry[i][1]) begin
                branches_taken[i] = gshare_entry[i][1];
            end else begin
                branches_taken[i] = simple_entry[i][1];
            end
        end
    end

endmodule

// File: verilog/branch_rank.sv
`timescale 1ns/10ps

module branch_rank (
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                          branch_mask,
    input  logic                                                    fetch_valid,
    output logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::FETCH_WIDTH-1:0] grant_bus,
    output logic [bp_pkg::FETCH_WIDTH-1:0]                          last_grant
);
    import bp_pkg::*;

    logic [FETCH_WIDTH-1:0] lane_valid;

    assign lane_valid = branch_mask & {FETCH_WIDTH{fetch_valid}};

    // Rank of a lane is the number of branches in the lanes below it
    always_comb begin
        int older;
        grant_bus = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            older = 0;
            for (int k = 0; k < i; k++) begin
                older = older + int'(lane_valid[k]);
            end
            if (lane_valid[i]) begin
                grant_bus[older][i] = 1'b1;
            end
        end
    end

    // Youngest branch sits in the highest occupied row
    always_comb begin
        last_grant = '0;
        for (int j = 0; j < FETCH_WIDTH; j++) begin
            if (|grant_bus[j]) begin
                last_grant = grant_bus[j];
            end
        end
    end

    // No two lanes may share a rank
    always_comb begin
        for (int j = 0; j < FETCH_WIDTH; j++) begin
            assert final ($onehot0(grant_bus[j]));
        end
    end

endmodule

// File: verilog/branch_stack.sv
`timescale 1ns/10ps

module branch_stack (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::FETCH_WIDTH-1:0] grant_bus,
    input  bp_pkg::bp_packet_t [bp_pkg::FETCH_WIDTH-1:0]            lane_packets,
    output bp_pkg::tag_t       [bp_pkg::FETCH_WIDTH-1:0]            branch_tags,
    output logic                                                    stack_full,
    input  logic                                                    resolve_valid,
    input  bp_pkg::tag_t                                            resolve_tag,
    input  logic                                                    mispred,
    output bp_pkg::bp_packet_t                                      resolved_packet
);
    import bp_pkg::*;

    bp_packet_t [STACK_DEPTH-1:0] packets;
    logic       [STACK_DEPTH-1:0] entry_valid;
    tag_t                         head;
    logic       [TAG_BITS:0]      free_count;
    logic       [TAG_BITS:0]      alloc_count;
    logic       [TAG_BITS:0]      alloc_step;
    logic       [FETCH_WIDTH-1:0] row_used;
    bp_packet_t [FETCH_WIDTH-1:0] row_packet;
    logic                         allocate;
    logic                         flush;

    assign flush      = resolve_valid && mispred;
    assign stack_full = free_count < (TAG_BITS+1)'(FETCH_WIDTH);
    // Groups arriving while full are dropped
    assign allocate   = !stack_full && !flush;
    assign alloc_step = allocate ? alloc_count : '0;

    assign resolved_packet = packets[resolve_tag];

    // Rank j takes head plus j
    always_comb begin
        branch_tags = '0;
        row_packet  = '0;
        row_used    = '0;
        alloc_count = '0;
        for (int j = 0; j < FETCH_WIDTH; j++) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (grant_bus[j][i]) begin
                    branch_tags[i] = tag_t'(head + j);
                    row_packet[j]  = lane_packets[i];
                end
            end
            row_used[j] = |grant_bus[j];
            alloc_count = alloc_count + row_used[j];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            head        <= '0;
            free_count  <= (TAG_BITS+1)'(STACK_DEPTH);
        end else if (flush) begin
            // Everything younger than the mispredicted branch is gone
            entry_valid <= '0;
            head        <= tag_t'(resolve_tag + 1'b1);
            free_count  <= (TAG_BITS+1)'(STACK_DEPTH);
        end else begin
            if (resolve_valid) begin
                entry_valid[resolve_tag] <= 1'b0;
            end
            if (allocate) begin
                for (int j = 0; j < FETCH_WIDTH; j++) begin
                    if (row_used[j]) begin
                        entry_valid[tag_t'(head + j)] <= 1'b1;
                    end
                end
                head <= tag_t'(head + alloc_count);
            end
            free_count <= free_count - alloc_step + resolve_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (allocate) begin
            for (int j = 0; j < FETCH_WIDTH; j++) begin
                if (row_used[j]) begin
                    packets[tag_t'(head + j)] <= row_packet[j];
                end
            end
        end
    end

    resolve_known_tag: assert property (@(posedge clock) disable iff (reset)
        resolve_valid |-> entry_valid[resolve_tag]);

    // Fetch has to hold branches back while the stack is full
    no_fetch_when_full: assert property (@(posedge clock) disable iff (reset)
        stack_full |-> !(|row_used));

endmodule

// File: verilog/counter_table.sv
`timescale 1ns/10ps

module counter_table #(
    parameter type entry_t = bp_pkg::counter_t
) (
    input  logic                                           clock,
    input  logic                                           reset,
    input  bp_pkg::pht_index_t [bp_pkg::FETCH_WIDTH-1:0]   read_index,
    output entry_t             [bp_pkg::FETCH_WIDTH-1:0]   read_entry,
    input  logic                                           train_valid,
    input  bp_pkg::pht_index_t                             train_index,
    input  logic                                           step_up,
    input  logic                                           step_down
);
    import bp_pkg::*;

    entry_t [PHT_SIZE-1:0] entries;
    entry_t                current_entry;
    entry_t                trained_entry;

    // Saturating step of the entry under training
    always_comb begin
        current_entry = entries[train_index];
        trained_entry = current_entry;
        if (step_up && current_entry != '1) begin
            trained_entry = entry_t'(current_entry + 1'b1);
        end else if (step_down && current_entry != '0) begin
            trained_entry = entry_t'(current_entry - 1'b1);
        end
    end

    // Reads see this cycle's training
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (train_valid && read_index[i] == train_index) begin
                read_entry[i] = trained_entry;
            end else begin
                read_entry[i] = entries[read_index[i]];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else if (train_valid) begin
            entries[train_index] <= trained_entry;
        end
    end

    // Callers must pick one direction per training step
    step_exclusive: assert property (@(posedge clock) disable iff (reset)
        train_valid |-> !(step_up && step_down));

endmodule

// File: verilog/fetch_branch_unit.sv
`timescale 1ns/10ps

module fetch_branch_unit (
    input  logic                                         clock,
    input  logic                                         reset,
    input  bp_pkg::addr_t      [bp_pkg::FETCH_WIDTH-1:0] pcs,
    input  logic               [bp_pkg::FETCH_WIDTH-1:0] branch_mask,
    input  logic               [bp_pkg::FETCH_WIDTH-1:0] btb_hits,
    input  logic                                         fetch_valid,
    input  logic                                         resolve_valid,
    input  bp_pkg::tag_t                                 resolve_tag,
    input  logic                                         taken,
    input  logic                                         mispred,
    output logic               [bp_pkg::FETCH_WIDTH-1:0] branches_taken,
    output bp_pkg::tag_t       [bp_pkg::FETCH_WIDTH-1:0] branch_tags,
    output logic                                         stack_full
);
    import bp_pkg::*;

    logic       [FETCH_WIDTH-1:0][FETCH_WIDTH-1:0] grant_bus;
    logic       [FETCH_WIDTH-1:0]                  last_grant;
    history_t   [FETCH_WIDTH-1:0]                  lane_history;
    bp_packet_t [FETCH_WIDTH-1:0]                  lane_packets;
    bp_packet_t                                    resolved_packet;

    branch_rank i_rank (
        .branch_mask (branch_mask),
        .fetch_valid (fetch_valid),
        .grant_bus   (grant_bus),
        .last_grant  (last_grant)
    );

    history_register i_history (
        .clock            (clock),
        .reset            (reset),
        .grant_bus        (grant_bus),
        .last_grant       (last_grant),
        .branches_taken   (branches_taken),
        .resolve_valid    (resolve_valid),
        .mispred          (mispred),
        .taken            (taken),
        .resolved_history (resolved_packet.history_state),
        .lane_history     (lane_history)
    );

    branch_predictor i_predictor (
        .clock           (clock),
        .reset           (reset),
        .pcs             (pcs),
        .btb_hits        (btb_hits),
        .lane_history    (lane_history),
        .lane_packets    (lane_packets),
        .branches_taken  (branches_taken),
        .resolve_valid   (resolve_valid),
        .taken           (taken),
        .resolved_packet (resolved_packet)
    );

    branch_stack i_stack (
        .clock           (clock),
        .reset           (reset),
        .grant_bus       (grant_bus),
        .lane_packets    (lane_packets),
        .branch_tags     (branch_tags),
        .stack_full      (stack_full),
        .resolve_valid   (resolve_valid),
        .resolve_tag     (resolve_tag),
        .mispred         (mispred),
        .resolved_packet (resolved_packet)
    );

endmodule

// File: verilog/history_register.sv
`timescale 1ns/10ps

module history_register (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::FETCH_WIDTH-1:0] grant_bus,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                          last_grant,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                          branches_taken,
    input  logic                                                    resolve_valid,
    input  logic                                                    mispred,
    input  logic                                                    taken,
    input  bp_pkg::history_t                                        resolved_history,
    output bp_pkg::history_t [bp_pkg::FETCH_WIDTH-1:0]              lane_history
);
    import bp_pkg::*;

    history_t                   history;
    history_t                   next_history;
    history_t [FETCH_WIDTH-1:0] rank_history;

    // A younger branch in the group is only reached if the older ones fell through,
    // so each rank adds one not-taken bit
    always_comb begin
        for (int j = 0; j < FETCH_WIDTH; j++) begin
            rank_history[j] = history_t'(history << j);
        end
    end

    // Map ranks back onto lanes, lanes without a branch read zero
    always_comb begin
        lane_history = '0;
        for (int j = 0; j < FETCH_WIDTH; j++) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (grant_bus[j][i]) begin
                    lane_history[i] = rank_history[j];
                end
            end
        end
    end

    always_comb begin
        next_history = history;
        // Advance past the youngest branch with its own prediction
        for (int j = 0; j < FETCH_WIDTH; j++) begin
            if (|last_grant && grant_bus[j] == last_grant) begin
                next_history = {rank_history[j][HISTORY_BITS-2:0],
                                |(last_grant & branches_taken)};
            end
        end
        // Mispredict wins over the fetch advance
        if (resolve_valid && mispred) begin
            next_history = {resolved_history[HISTORY_BITS-2:0], taken};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
        end else begin
            history <= next_history;
        end
    end

endmodule
